// File: logic/oa_pkg.sv
// output-activation writer shared definitions
// tile geometry constants, address and count types,
// configuration, bus command and data beat structs
package oa_pkg;

  // ==========================================================
  // tile geometry constants
  // ==========================================================
  // tile edge in elements, one byte each
  localparam int TILE_DIM       = 16;
  // log2 of tile edge
  localparam int TILE_SHIFT     = 4;
  // bytes carried by one 32-bit bus beat
  localparam int BYTES_PER_BEAT = 4;

  // ==========================================================
  // scalar types
  // ==========================================================
  // byte address, also used for stride and matrix dimensions
  typedef logic [31:0] addr_t;
  // element count inside one tile, 0..16
  typedef logic [4:0]  dim_t;
  // tile counter and tile row / column index
  typedef logic [15:0] tile_idx_t;
  // bus burst length minus one
  typedef logic [2:0]  len_t;

  // ==========================================================
  // structs
  // ==========================================================
  // matrix configuration, latched on init strobe
  typedef struct packed {
    addr_t dst_base;
    addr_t row_stride;
    addr_t num_rows;
    addr_t num_cols;
  } oa_cfg_t;

  // per-tile geometry handed out by the walker
  typedef struct packed {
    addr_t tile_base;
    dim_t  rows;
    dim_t  cols;
    dim_t  beats_per_row;
  } tile_geom_t;

  // bus write command channel, master side
  typedef struct packed {
    logic  valid;
    addr_t addr;
    len_t  len;
  } icb_cmd_t;

  // bus write data channel, master side
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic [3:0]  mask;
  } icb_wr_t;

  // upstream FIFO beat payload
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  mask;
  } oa_beat_t;

endpackage

// File: logic/oa_tile_walker.sv
// tile walker for the output-activation writer
// latches the matrix configuration, walks 16x16 tiles column tile first,
// requests the bus per tile and publishes per-tile geometry
`timescale 1ns/1ps

module oa_tile_walker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               init_cfg_i,
  input  oa_pkg::oa_cfg_t    cfg_i,
  input  logic               write_oa_granted_i,
  input  logic               cmds_done_i,
  input  logic               tile_beats_done_i,
  output logic               write_oa_req_o,
  output logic               tile_start_o,
  output oa_pkg::tile_geom_t geom_o,
  output oa_pkg::addr_t      row_stride_o,
  output logic               write_done_o,
  output logic               calc_over_o
);
  import oa_pkg::*;

  typedef enum logic [1:0] {IDLE, REQ, GRANTED, BUSY} walk_state_e;

  walk_state_e state_q;
  oa_cfg_t     cfg_q;
  tile_idx_t   n_tcol_q;
  tile_idx_t   trow_q;
  tile_idx_t   tcol_q;
  tile_idx_t   tiles_left_q;
  tile_geom_t  geom_q;
  tile_geom_t  geom_next;
  dim_t        cols_next;
  logic        calc_over_q;
  tile_idx_t   cfg_trows;
  tile_idx_t   cfg_tcols;
  tile_idx_t   cfg_tiles;
  logic        tile_done;

  // ceil(n / 16) without overflow on large n
  function automatic tile_idx_t ceil_tiles(addr_t n);
    return tile_idx_t'((n >> TILE_SHIFT) + addr_t'(n[TILE_SHIFT-1:0] != '0));
  endfunction

  // elements left in this tile, clamped to the tile edge
  function automatic dim_t clamp_dim(addr_t total, tile_idx_t idx);
    addr_t remain;
    remain = total - (addr_t'(idx) << TILE_SHIFT);
    if (remain >= addr_t'(TILE_DIM)) begin
      return dim_t'(TILE_DIM);
    end
    return dim_t'(remain);
  endfunction

  // ==========================================================
  // tile count straight from the strobe cycle
  // ==========================================================
  assign cfg_trows = ceil_tiles(cfg_i.num_rows);
  assign cfg_tcols = ceil_tiles(cfg_i.num_cols);
  assign cfg_tiles = tile_idx_t'(cfg_trows * cfg_tcols);

  // geometry of the tile at the current indices
  assign cols_next = clamp_dim(cfg_q.num_cols, tcol_q);

  always_comb begin
    geom_next.rows          = clamp_dim(cfg_q.num_rows, trow_q);
    geom_next.cols          = cols_next;
    // one beat per started group of 4 bytes
    geom_next.beats_per_row = dim_t'((cols_next + BYTES_PER_BEAT - 1) / BYTES_PER_BEAT);
    geom_next.tile_base     = cfg_q.dst_base
                            + (addr_t'(trow_q) << TILE_SHIFT) * cfg_q.row_stride
                            + (addr_t'(tcol_q) << TILE_SHIFT);
  end

  // tile ends when every row is commanded and the last beat moves
  assign tile_done = (state_q == BUSY) && tile_beats_done_i && cmds_done_i;

  // ==========================================================
  // grant FSM and tile walk
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      cfg_q        <= '0;
      n_tcol_q     <= '0;
      trow_q       <= '0;
      tcol_q       <= '0;
      tiles_left_q <= '0;
      geom_q       <= '0;
      calc_over_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (init_cfg_i) begin
            cfg_q        <= cfg_i;
            n_tcol_q     <= cfg_tcols;
            trow_q       <= '0;
            tcol_q       <= '0;
            tiles_left_q <= cfg_tiles;
            // empty matrix finishes at once
            calc_over_q  <= (cfg_tiles == '0);
            if (cfg_tiles != '0) begin
              state_q <= REQ;
            end
          end
        end
        REQ: begin
          // snapshot geometry as the grant lands
          if (write_oa_granted_i) begin
            geom_q  <= geom_next;
            state_q <= GRANTED;
          end
        end
        GRANTED: begin
          state_q <= BUSY;
        end
        BUSY: begin
          if (tile_done) begin
            tiles_left_q <= tiles_left_q - 1'b1;
            // column tile first, wrap to next tile row
            if (tcol_q == n_tcol_q - 1'b1) begin
              tcol_q <= '0;
              trow_q <= trow_q + 1'b1;
            end else begin
              tcol_q <= tcol_q + 1'b1;
            end
            if (tiles_left_q == tile_idx_t'(1)) begin
              calc_over_q <= 1'b1;
              state_q     <= IDLE;
            end else begin
              state_q <= REQ;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign write_oa_req_o = (state_q == REQ);
  assign tile_start_o   = (state_q == GRANTED);
  assign geom_o         = geom_q;
  assign row_stride_o   = cfg_q.row_stride;
  assign write_done_o   = tile_done;
  assign calc_over_o    = calc_over_q;

  // bus request only while work remains
  a_req_not_over: assert property (@(posedge clk) disable iff (!rst_n)
    !(write_oa_req_o && calc_over_o));

  // data side may only finish a tile the walker has started
  a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tile_beats_done_i |-> (state_q == BUSY));

endmodule

// File: logic/oa_row_cmd_gen.sv
// row command generator
// issues one bus write command per tile row, running at most
// CMD_CREDITS rows ahead of the data side
`timescale 1ns/1ps

module oa_row_cmd_gen #(
  parameter int CMD_CREDITS = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               tile_start_i,
  input  oa_pkg::tile_geom_t geom_i,
  input  oa_pkg::addr_t      row_stride_i,
  input  logic               icb_cmd_ready_i,
  input  logic               row_retired_i,
  output oa_pkg::icb_cmd_t   icb_cmd_o,
  output logic               row_issued_o,
  output logic               cmds_done_o
);
  import oa_pkg::*;

  localparam int CW = $clog2(CMD_CREDITS + 1);

  typedef logic [CW-1:0] credit_t;

  credit_t credits_q;
  dim_t    rows_left_q;
  addr_t   row_addr_q;
  dim_t    cur_rows_left;
  addr_t   cur_addr;
  logic    cmd_fire;

  // ==========================================================
  // current row view
  // ==========================================================
  // tile start bypasses the registers so the first command
  // goes out in the start cycle
  assign cur_rows_left = tile_start_i ? geom_i.rows : rows_left_q;
  assign cur_addr      = tile_start_i ? geom_i.tile_base : row_addr_q;

  always_comb begin
    icb_cmd_o.valid = (cur_rows_left != '0) && (credits_q != '0);
    icb_cmd_o.addr  = cur_addr;
    // burst of ceil(cols/4) beats
    icb_cmd_o.len   = len_t'(geom_i.beats_per_row - 5'd1);
  end

  assign cmd_fire     = icb_cmd_o.valid && icb_cmd_ready_i;
  assign row_issued_o = cmd_fire;
  // level, all rows of this tile are on the bus
  assign cmds_done_o  = !tile_start_i && (rows_left_q == '0);

  // ==========================================================
  // row and credit counters
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rows_left_q <= '0;
      credits_q   <= credit_t'(CMD_CREDITS);
    end else begin
      rows_left_q <= cur_rows_left - dim_t'(cmd_fire);
      // spend one per command, regain one per retired row
      credits_q   <= credits_q - credit_t'(cmd_fire) + credit_t'(row_retired_i);
    end
  end

  // running row address, next row is one stride further
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      row_addr_q <= cur_addr + row_stride_i;
    end else begin
      row_addr_q <= cur_addr;
    end
  end

  // command held while the bus stalls it
  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    icb_cmd_o.valid && !icb_cmd_ready_i |=> $stable(icb_cmd_o));

endmodule

// File: logic/oa_beat_tracker.sv
// beat tracker
// gates upstream beats onto the bus write channel while a row command
// is outstanding, counts beats per row and rows per tile
`timescale 1ns/1ps

module oa_beat_tracker #(
  parameter int CMD_CREDITS = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               tile_start_i,
  input  oa_pkg::tile_geom_t geom_i,
  input  logic               row_issued_i,
  input  logic               oa_valid_i,
  input  oa_pkg::oa_beat_t   oa_beat_i,
  input  logic               icb_wr_ready_i,
  output logic               oa_ready_o,
  output oa_pkg::icb_wr_t    icb_wr_o,
  output logic               row_retired_o,
  output logic               tile_beats_done_o
);
  import oa_pkg::*;

  localparam int CW = $clog2(CMD_CREDITS + 1);

  typedef logic [CW-1:0] credit_t;

  credit_t credits_q;
  logic    active_q;
  dim_t    beat_cnt_q;
  dim_t    rows_left_q;
  logic    permit;
  logic    beat_fire;
  logic    last_beat;
  logic    last_row;

  // ==========================================================
  // data path, combinational pass-through
  // ==========================================================
  // beats move only for rows already commanded
  assign permit     = active_q && (credits_q != '0);
  assign oa_ready_o = permit && icb_wr_ready_i;

  always_comb begin
    icb_wr_o.valid = oa_valid_i && permit;
    icb_wr_o.data  = oa_beat_i.data;
    icb_wr_o.mask  = oa_beat_i.mask;
  end

  assign beat_fire = oa_valid_i && oa_ready_o;
  assign last_beat = beat_fire && (beat_cnt_q == geom_i.beats_per_row - 5'd1);
  assign last_row  = (rows_left_q == 5'd1);

  assign row_retired_o     = last_beat;
  assign tile_beats_done_o = last_beat && last_row;

  // ==========================================================
  // credits and counters
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits_q   <= '0;
      active_q    <= 1'b0;
      beat_cnt_q  <= '0;
      rows_left_q <= '0;
    end else begin
      // one credit per commanded row, returned at row end
      credits_q <= credits_q + credit_t'(row_issued_i) - credit_t'(row_retired_o);
      if (tile_start_i) begin
        active_q    <= 1'b1;
        beat_cnt_q  <= '0;
        rows_left_q <= geom_i.rows;
      end else if (beat_fire) begin
        if (last_beat) begin
          beat_cnt_q  <= '0;
          rows_left_q <= rows_left_q - 5'd1;
          // tile finished on the data side
          if (last_row) begin
            active_q <= 1'b0;
          end
        end else begin
          beat_cnt_q <= beat_cnt_q + 5'd1;
        end
      end
    end
  end

  // command side never runs further ahead than the credit pool
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits_q <= credit_t'(CMD_CREDITS));

endmodule

// File: logic/oa_writer.sv
// output-activation writer top level
// tile walker plus command generator and beat tracker running side by side,
// with credit flow control between the two parallel parts
`timescale 1ns/1ps

module oa_writer #(
  parameter int CMD_CREDITS = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  // configuration
  input  logic             init_cfg_i,
  input  oa_pkg::oa_cfg_t  cfg_i,
  // bus grant handshake
  output logic             write_oa_req_o,
  input  logic             write_oa_granted_i,
  // upstream FIFO
  input  logic             oa_valid_i,
  input  oa_pkg::oa_beat_t oa_beat_i,
  output logic             oa_ready_o,
  // bus command channel
  output oa_pkg::icb_cmd_t icb_cmd_o,
  input  logic             icb_cmd_ready_i,
  // bus write channel
  output oa_pkg::icb_wr_t  icb_wr_o,
  input  logic             icb_wr_ready_i,
  // status
  output logic             write_done_o,
  output logic             calc_over_o
);
  import oa_pkg::*;

  // ==========================================================
  // internal wires
  // ==========================================================
  logic       tile_start;
  tile_geom_t geom;
  addr_t      row_stride;
  // credit loop
  logic       row_issued;
  logic       row_retired;
  // completion inputs for the walker
  logic       cmds_done;
  logic       tile_beats_done;

  oa_tile_walker u_walker (
    .clk                (clk),
    .rst_n              (rst_n),
    .init_cfg_i         (init_cfg_i),
    .cfg_i              (cfg_i),
    .write_oa_granted_i (write_oa_granted_i),
    .cmds_done_i        (cmds_done),
    .tile_beats_done_i  (tile_beats_done),
    .write_oa_req_o     (write_oa_req_o),
    .tile_start_o       (tile_start),
    .geom_o             (geom),
    .row_stride_o       (row_stride),
    .write_done_o       (write_done_o),
    .calc_over_o        (calc_over_o)
  );

  // command side
  oa_row_cmd_gen #(
    .CMD_CREDITS (CMD_CREDITS)
  ) u_cmd_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .tile_start_i    (tile_start),
    .geom_i          (geom),
    .row_stride_i    (row_stride),
    .icb_cmd_ready_i (icb_cmd_ready_i),
    .row_retired_i   (row_retired),
    .icb_cmd_o       (icb_cmd_o),
    .row_issued_o    (row_issued),
    .cmds_done_o     (cmds_done)
  );

  // data side
  oa_beat_tracker #(
    .CMD_CREDITS (CMD_CREDITS)
  ) u_beat_tracker (
    .clk               (clk),
    .rst_n             (rst_n),
    .tile_start_i      (tile_start),
    .geom_i            (geom),
    .row_issued_i      (row_issued),
    .oa_valid_i        (oa_valid_i),
    .oa_beat_i         (oa_beat_i),
    .icb_wr_ready_i    (icb_wr_ready_i),
    .oa_ready_o        (oa_ready_o),
    .icb_wr_o          (icb_wr_o),
    .row_retired_o     (row_retired),
    .tile_beats_done_o (tile_beats_done)
  );

endmodule

// File: tests/oa_checker.sv
// scoreboard for the output-activation writer
// rebuilds the expected row command walk from each configuration and
// checks commands, beats, grant handshake and tile status every cycle
`timescale 1ns/1ps

module oa_checker #(
  parameter int CMD_CREDITS = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             init_cfg_i,
  input  oa_pkg::oa_cfg_t  cfg_i,
  input  logic             req_i,
  input  logic             grant_i,
  input  logic             up_valid_i,
  input  oa_pkg::oa_beat_t up_beat_i,
  input  logic             up_ready_i,
  input  oa_pkg::icb_cmd_t cmd_i,
  input  logic             cmd_ready_i,
  input  oa_pkg::icb_wr_t  wr_i,
  input  logic             wr_ready_i,
  input  logic             done_i,
  input  logic             over_i,
  output int               err_cnt_o,
  output int               cmd_cnt_o,
  output int               beat_cnt_o,
  output int               tile_cnt_o
);
  import oa_pkg::*;

  // expected command stream, one entry per tile row
  addr_t     exp_addr_q[$];
  len_t      exp_len_q[$];
  // rows per tile, front entry is the tile in flight
  int        tile_rows_q[$];
  // beats still owed by each commanded row
  int        row_beats_q[$];
  int        tile_cmds;
  int        err_cnt  = 0;
  int        cmd_cnt  = 0;
  int        beat_cnt = 0;
  int        tile_cnt = 0;
  logic      exp_req;
  logic      exp_over;
  logic      granted;
  logic      seen_init;
  logic      stall_q;
  icb_cmd_t  cmd_prev;

  assign err_cnt_o  = err_cnt;
  assign cmd_cnt_o  = cmd_cnt;
  assign beat_cnt_o = beat_cnt;
  assign tile_cnt_o = tile_cnt;

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // ==========================================================
  // expected walk, column tile first inside each tile row
  // ==========================================================
  task automatic load_walk(input oa_cfg_t cfg);
    int trows;
    int tcols;
    int rows;
    int cols;
    exp_addr_q.delete();
    exp_len_q.delete();
    tile_rows_q.delete();
    trows = int'((cfg.num_rows + 15) / 16);
    tcols = int'((cfg.num_cols + 15) / 16);
    for (int tr = 0; tr < trows; tr++) begin
      for (int tc = 0; tc < tcols; tc++) begin
        // edge tiles keep only what is left of the matrix
        rows = (int'(cfg.num_rows) - tr * 16 > 16) ? 16 : int'(cfg.num_rows) - tr * 16;
        cols = (int'(cfg.num_cols) - tc * 16 > 16) ? 16 : int'(cfg.num_cols) - tc * 16;
        tile_rows_q.push_back(rows);
        for (int r = 0; r < rows; r++) begin
          exp_addr_q.push_back(cfg.dst_base + addr_t'(tr * 16 + r) * cfg.row_stride
                               + addr_t'(tc * 16));
          exp_len_q.push_back(len_t'((cols + 3) / 4 - 1));
        end
      end
    end
  endtask

  always @(posedge clk) begin
    logic cmd_fire;
    logic up_fire;
    logic wr_fire;
    logic exp_done;
    if (!rst_n) begin
      row_beats_q.delete();
      tile_rows_q.delete();
      exp_req   = 1'b0;
      exp_over  = 1'b0;
      granted   = 1'b0;
      seen_init = 1'b0;
      stall_q   = 1'b0;
      tile_cmds = 0;
    end else begin
      cmd_fire = cmd_i.valid && cmd_ready_i;
      up_fire  = up_valid_i && up_ready_i;
      wr_fire  = wr_i.valid && wr_ready_i;
      exp_done = 1'b0;
      // status outputs against the cycle model
      if (req_i !== exp_req)
        flag_error($sformatf("write_oa_req_o is %b, expected %b", req_i, exp_req));
      if (over_i !== exp_over)
        flag_error($sformatf("calc_over_o is %b, expected %b", over_i, exp_over));
      if (!seen_init && (cmd_i.valid || wr_i.valid || up_ready_i || done_i))
        flag_error("control output high before the first configuration");
      if (stall_q && (!cmd_i.valid || cmd_i.addr !== cmd_prev.addr || cmd_i.len !== cmd_prev.len))
        flag_error("command changed while stalled by the bus");
      if (up_fire !== wr_fire)
        flag_error("upstream and bus write transfers disagree");
      if (wr_fire && (wr_i.data !== up_beat_i.data || wr_i.mask !== up_beat_i.mask))
        flag_error($sformatf("write beat %h/%h, upstream %h/%h", wr_i.data, wr_i.mask,
                             up_beat_i.data, up_beat_i.mask));
      if ((cmd_fire || wr_fire) && !granted)
        flag_error("transfer without a bus grant for this tile");

      // beats retire rows in command order
      if (wr_fire) begin
        beat_cnt++;
        if (row_beats_q.size() == 0) begin
          flag_error("write beat before its row command");
        end else begin
          row_beats_q[0] = row_beats_q[0] - 1;
          if (row_beats_q[0] == 0) begin
            row_beats_q.pop_front();
            exp_done = (row_beats_q.size() == 0) && (tile_rows_q.size() != 0)
                       && (tile_cmds == tile_rows_q[0]);
          end
        end
      end

      if (cmd_fire) begin
        cmd_cnt++;
        tile_cmds++;
        if (exp_addr_q.size() == 0) begin
          flag_error($sformatf("unexpected command addr %h", cmd_i.addr));
        end else begin
          if (cmd_i.addr !== exp_addr_q[0] || cmd_i.len !== exp_len_q[0])
            flag_error($sformatf("command addr %h len %0d, expected addr %h len %0d",
                                 cmd_i.addr, cmd_i.len, exp_addr_q[0], exp_len_q[0]));
          row_beats_q.push_back(int'(exp_len_q[0]) + 1);
          exp_addr_q.pop_front();
          exp_len_q.pop_front();
        end
      end
      if (row_beats_q.size() > CMD_CREDITS)
        flag_error($sformatf("%0d rows outstanding, limit %0d", row_beats_q.size(), CMD_CREDITS));

      // ==========================================================
      // tile completion and grant model
      // ==========================================================
      if (done_i !== exp_done)
        flag_error($sformatf("write_done_o is %b, expected %b", done_i, exp_done));
      if (exp_done) begin
        tile_cnt++;
        tile_rows_q.pop_front();
        tile_cmds = 0;
        granted   = 1'b0;
        if (tile_rows_q.size() == 0) begin
          exp_over = 1'b1;
        end else begin
          exp_req = 1'b1;
        end
      end
      if (exp_req && grant_i) begin
        granted = 1'b1;
        exp_req = 1'b0;
      end
      if (init_cfg_i) begin
        seen_init = 1'b1;
        load_walk(cfg_i);
        row_beats_q.delete();
        tile_cmds = 0;
        granted   = 1'b0;
        exp_req   = (tile_rows_q.size() != 0);
        exp_over  = (tile_rows_q.size() == 0);
      end
      stall_q  = cmd_i.valid && !cmd_ready_i;
      cmd_prev = cmd_i;
    end
  end

endmodule

// File: tests/tb_oa_writer.sv
// testbench for the output-activation writer
// random matrix sizes, bus back-pressure and grant delays from an LFSR,
// several configurations back to back, checking done in oa_checker
`timescale 1ns/1ps

module tb_oa_writer;
  import oa_pkg::*;

  localparam int CMD_CREDITS = 2;
  localparam int N_CFG       = 12;
  localparam int WAIT_LIMIT  = 20000;

  logic        clk;
  logic        rst_n;
  logic        init_cfg_i;
  oa_cfg_t     cfg_i;
  logic        write_oa_req_o;
  logic        write_oa_granted_i;
  logic        oa_valid_i;
  oa_beat_t    oa_beat_i;
  logic        oa_ready_o;
  icb_cmd_t    icb_cmd_o;
  logic        icb_cmd_ready_i;
  icb_wr_t     icb_wr_o;
  logic        icb_wr_ready_i;
  logic        write_done_o;
  logic        calc_over_o;
  int          err_cnt;
  int          cmd_cnt;
  int          beat_cnt;
  int          tile_cnt;
  logic [31:0] lfsr_state = 32'h5234;
  logic        up_taken   = 1'b0;
  logic        models_on  = 1'b0;
  int          gnt_wait;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit handed out
  function logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  oa_writer #(
    .CMD_CREDITS (CMD_CREDITS)
  ) i_oa_writer (
    .clk                (clk),
    .rst_n              (rst_n),
    .init_cfg_i         (init_cfg_i),
    .cfg_i              (cfg_i),
    .write_oa_req_o     (write_oa_req_o),
    .write_oa_granted_i (write_oa_granted_i),
    .oa_valid_i         (oa_valid_i),
    .oa_beat_i          (oa_beat_i),
    .oa_ready_o         (oa_ready_o),
    .icb_cmd_o          (icb_cmd_o),
    .icb_cmd_ready_i    (icb_cmd_ready_i),
    .icb_wr_o           (icb_wr_o),
    .icb_wr_ready_i     (icb_wr_ready_i),
    .write_done_o       (write_done_o),
    .calc_over_o        (calc_over_o)
  );

  oa_checker #(
    .CMD_CREDITS (CMD_CREDITS)
  ) u_oa_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_cfg_i  (init_cfg_i),
    .cfg_i       (cfg_i),
    .req_i       (write_oa_req_o),
    .grant_i     (write_oa_granted_i),
    .up_valid_i  (oa_valid_i),
    .up_beat_i   (oa_beat_i),
    .up_ready_i  (oa_ready_o),
    .cmd_i       (icb_cmd_o),
    .cmd_ready_i (icb_cmd_ready_i),
    .wr_i        (icb_wr_o),
    .wr_ready_i  (icb_wr_ready_i),
    .done_i      (write_done_o),
    .over_i      (calc_over_o),
    .err_cnt_o   (err_cnt),
    .cmd_cnt_o   (cmd_cnt),
    .beat_cnt_o  (beat_cnt),
    .tile_cnt_o  (tile_cnt)
  );

  // upstream beat taken and reset state, both as seen at the clock edge
  always @(posedge clk) begin
    up_taken  <= oa_valid_i && oa_ready_o;
    models_on <= rst_n;
  end

  // ==========================================================
  // bus, FIFO and grant controller models
  // ==========================================================
  initial begin
    icb_cmd_ready_i    = 1'b0;
    icb_wr_ready_i     = 1'b0;
    oa_valid_i         = 1'b0;
    oa_beat_i          = '0;
    write_oa_granted_i = 1'b0;
    gnt_wait           = -1;
    forever begin
      @(negedge clk);
      if (models_on) begin
        // ready about 75% of the time
        icb_cmd_ready_i = (take_bits(2) != 0);
        icb_wr_ready_i  = (take_bits(2) != 0);
        // FIFO holds a beat until it is taken
        if (!oa_valid_i || up_taken) begin
          oa_valid_i     = (take_bits(2) != 0);
          oa_beat_i.data = take_bits(32);
          oa_beat_i.mask = 4'(take_bits(4));
        end
        if (write_oa_granted_i) begin
          write_oa_granted_i = 1'b0;
        end else if (write_oa_req_o) begin
          if (gnt_wait < 0) begin
            gnt_wait = take_bits(3);
          end
          if (gnt_wait == 0) begin
            write_oa_granted_i = 1'b1;
            gnt_wait           = -1;
          end else begin
            gnt_wait--;
          end
        end
      end
    end
  end

  initial begin
    oa_cfg_t cfg;
    int      wait_cnt;
    logic    timed_out;
    rst_n      = 1'b0;
    init_cfg_i = 1'b0;
    cfg_i      = '0;
    timed_out  = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    for (int n = 0; n < N_CFG && !timed_out; n++) begin
      // draw sizes away from the falling edge used by the bus model
      @(posedge clk);
      cfg.num_rows   = 1 + take_bits(6) % 40;
      cfg.num_cols   = 1 + take_bits(6) % 40;
      cfg.row_stride = cfg.num_cols + take_bits(5);
      cfg.dst_base   = take_bits(20);
      @(negedge clk);
      init_cfg_i = 1'b1;
      cfg_i      = cfg;
      @(negedge clk);
      init_cfg_i = 1'b0;
      wait_cnt   = 0;
      while (!calc_over_o && wait_cnt < WAIT_LIMIT) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (!calc_over_o) begin
        $display("timeout: configuration %0d (%0d x %0d) never finished",
                 n, cfg.num_rows, cfg.num_cols);
        timed_out = 1'b1;
      end
    end
    // let the checker see the final status cycle
    repeat (2) @(negedge clk);
    $display("checker: %0d commands, %0d beats, %0d tiles, %0d errors",
             cmd_cnt, beat_cnt, tile_cnt, err_cnt);
    if (timed_out || err_cnt != 0) begin
      $display("SOME TESTS FAILED");
    end else begin
      $display("ALL TESTS PASSED");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/oa_pkg.sv
logic/oa_tile_walker.sv
logic/oa_row_cmd_gen.sv
logic/oa_beat_tracker.sv
logic/oa_writer.sv
tests/oa_checker.sv
tests/tb_oa_writer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_oa_writer
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
